// ==== hw/render_pkg.sv ====
package render_pkg;

    // Frame buffer geometry.
    localparam int FB_WIDTH = 16;
    localparam int FB_HEIGHT = 12;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;
    localparam int ADDR_WIDTH = 8;

    typedef logic [3:0] coord_t;

    // 4 bits each of red, green and blue.
    typedef logic [11:0] color_t;

    // Holds any difference of two coordinate-difference products.
    typedef logic signed [9:0] edge_t;

    // Screen-space triangle in the ROM word layout with x0 in the top nibble.
    typedef struct packed {
        coord_t x0;
        coord_t y0;
        coord_t x1;
        coord_t y1;
        coord_t x2;
        coord_t y2;
        color_t color;
    } triangle_t;

    typedef enum logic [2:0] {
        IDLE,
        BACKGROUND,
        GRAPHICS,
        MARKER,
        FRAME_DONE
    } draw_state_t;

endpackage

// ==== hw/triangle_rom.sv ====
`timescale 1ns/10ps

module triangle_rom #(
    parameter int TRI_COUNT = 4
) (
    input  logic                         clk,
    input  logic [$clog2(TRI_COUNT)-1:0] addr,
    output render_pkg::triangle_t        data
);

    logic [$bits(render_pkg::triangle_t)-1:0] mem [TRI_COUNT];

    // One triangle per line of 9 hex digits.
    initial begin
        $readmemh("triangles.hex", mem);
    end

    // Registered read so data follows addr by one cycle.
    always_ff @(posedge clk) begin
        data <= mem[addr];
    end

endmodule

// ==== hw/triangle_setup.sv ====
`timescale 1ns/10ps

module triangle_setup #(
    parameter int LANES = 4,
    parameter int TRI_COUNT = 4
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         raster_start,
    input  logic                         busy,
    output logic [$clog2(TRI_COUNT)-1:0] rom_addr,
    input  render_pkg::triangle_t        rom_data,
    output logic                         chunk_valid,
    output render_pkg::coord_t           chunk_x,
    output render_pkg::coord_t           chunk_y,
    output render_pkg::triangle_t        chunk_tri,
    output logic                         raster_done
);

    localparam int IDX_WIDTH = $clog2(TRI_COUNT);

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_LOAD,
        S_SCAN,
        S_DRAIN
    } setup_state_t;

    setup_state_t state;
    logic [IDX_WIDTH-1:0] tri_idx;
    render_pkg::coord_t x_min, x_max, y_min, y_max, x_base;
    render_pkg::coord_t x_start, x_hi, y_hi;
    logic row_end, box_end, issue;

    function automatic render_pkg::coord_t min3(input render_pkg::coord_t a,
                                                input render_pkg::coord_t b,
                                                input render_pkg::coord_t c);
        render_pkg::coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic render_pkg::coord_t max3(input render_pkg::coord_t a,
                                                input render_pkg::coord_t b,
                                                input render_pkg::coord_t c);
        render_pkg::coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    ////////////////////////////////////////
    // Bounding box and scan position.
    ////////////////////////////////////////

    assign x_min = min3(rom_data.x0, rom_data.x1, rom_data.x2);
    assign x_max = max3(rom_data.x0, rom_data.x1, rom_data.x2);
    assign y_min = min3(rom_data.y0, rom_data.y1, rom_data.y2);
    assign y_max = max3(rom_data.y0, rom_data.y1, rom_data.y2);

    // Rows start on a lane-aligned column.
    assign x_base = render_pkg::coord_t'((x_min / LANES) * LANES);

    assign rom_addr = tri_idx;
    assign row_end = ({1'b0, chunk_x} + 5'(LANES)) > {1'b0, x_hi};
    assign box_end = row_end && (chunk_y == y_hi);

    // At most one chunk every other cycle, and never while lanes drain.
    assign issue = (state == S_SCAN) && !chunk_valid && !busy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
            tri_idx <= '0;
            chunk_valid <= 1'b0;
            raster_done <= 1'b0;
        end else begin
            chunk_valid <= issue;
            raster_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (raster_start) begin
                        state <= S_FETCH;
                    end
                end
                S_FETCH: state <= S_LOAD;
                S_LOAD: state <= S_SCAN;
                S_SCAN: begin
                    if (chunk_valid && box_end) begin
                        if (tri_idx == IDX_WIDTH'(TRI_COUNT - 1)) begin
                            state <= S_DRAIN;
                        end else begin
                            tri_idx <= tri_idx + 1'b1;
                            state <= S_FETCH;
                        end
                    end
                end
                S_DRAIN: begin
                    // Last chunk is out once the collector goes idle.
                    if (!busy) begin
                        raster_done <= 1'b1;
                        tri_idx <= '0;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_LOAD) begin
            chunk_tri <= rom_data;
            x_start <= x_base;
            x_hi <= x_max;
            y_hi <= y_max;
            chunk_x <= x_base;
            chunk_y <= y_min;
        end else if (state == S_SCAN && chunk_valid && !box_end) begin
            if (row_end) begin
                chunk_x <= x_start;
                chunk_y <= chunk_y + 1'b1;
            end else begin
                chunk_x <= render_pkg::coord_t'(chunk_x + LANES);
            end
        end
    end

endmodule

// ==== hw/edge_tester.sv ====
`timescale 1ns/10ps

module edge_tester #(
    parameter int LANE = 0
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              chunk_valid,
    input  render_pkg::coord_t                chunk_x,
    input  render_pkg::coord_t                chunk_y,
    input  render_pkg::triangle_t             chunk_tri,
    output logic                              lane_valid,
    output logic                              lane_covered,
    output logic [render_pkg::ADDR_WIDTH-1:0] lane_addr,
    output render_pkg::color_t                lane_color
);

    localparam int AW = render_pkg::ADDR_WIDTH;

    render_pkg::coord_t px;
    render_pkg::edge_t e01, e12, e20;
    logic covered;

    // (x - xa) * (yb - ya) - (y - ya) * (xb - xa).
    function automatic render_pkg::edge_t edge_fn(input render_pkg::coord_t xa,
                                                  input render_pkg::coord_t ya,
                                                  input render_pkg::coord_t xb,
                                                  input render_pkg::coord_t yb,
                                                  input render_pkg::coord_t x,
                                                  input render_pkg::coord_t y);
        render_pkg::edge_t dpx, dpy, ebx, eby;
        dpx = $signed({6'b0, x}) - $signed({6'b0, xa});
        dpy = $signed({6'b0, y}) - $signed({6'b0, ya});
        ebx = $signed({6'b0, xb}) - $signed({6'b0, xa});
        eby = $signed({6'b0, yb}) - $signed({6'b0, ya});
        return dpx * eby - dpy * ebx;
    endfunction

    assign px = render_pkg::coord_t'(chunk_x + LANE);

    assign e01 = edge_fn(chunk_tri.x0, chunk_tri.y0, chunk_tri.x1, chunk_tri.y1, px, chunk_y);
    assign e12 = edge_fn(chunk_tri.x1, chunk_tri.y1, chunk_tri.x2, chunk_tri.y2, px, chunk_y);
    assign e20 = edge_fn(chunk_tri.x2, chunk_tri.y2, chunk_tri.x0, chunk_tri.y0, px, chunk_y);

    // Same sign on all three edges lets either winding count as inside.
    assign covered = (e01 >= 0 && e12 >= 0 && e20 >= 0) ||
                     (e01 <= 0 && e12 <= 0 && e20 <= 0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= chunk_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (chunk_valid) begin
            lane_covered <= covered;
            lane_addr <= AW'(px) + AW'(chunk_y) * AW'(render_pkg::FB_WIDTH);
            lane_color <= chunk_tri.color;
        end
    end

endmodule

// ==== hw/pixel_collector.sv ====
`timescale 1ns/10ps

module pixel_collector #(
    parameter int LANES = 4
) (
    input  logic                                         clk,
    input  logic                                         rstn,
    input  logic [LANES-1:0]                             lane_valid,
    input  logic [LANES-1:0]                             lane_covered,
    input  logic [LANES-1:0][render_pkg::ADDR_WIDTH-1:0] lane_addr,
    input  render_pkg::color_t                           lane_color,
    output logic                                         busy,
    output logic                                         px_en,
    output logic [render_pkg::ADDR_WIDTH-1:0]            px_addr,
    output render_pkg::color_t                           px_data
);

    logic [LANES-1:0] mask;
    logic [LANES-1:0][render_pkg::ADDR_WIDTH-1:0] addr_r;
    render_pkg::color_t color_r;
    logic arriving;

    assign arriving = |lane_valid;
    assign busy = arriving || (|mask);
    assign px_en = |mask;
    assign px_data = color_r;

    // Lowest pending lane goes first.
    always_comb begin
        px_addr = addr_r[0];
        for (int i = LANES - 1; i >= 0; i--) begin
            if (mask[i]) begin
                px_addr = addr_r[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mask <= '0;
        end else if (arriving) begin
            mask <= lane_valid & lane_covered;
        end else begin
            // Drop the lane just emitted.
            mask <= mask & (mask - 1'b1);
        end
    end

    always_ff @(posedge clk) begin
        if (arriving) begin
            addr_r <= lane_addr;
            color_r <= lane_color;
        end
    end

endmodule

// ==== hw/background_drawer.sv ====
`timescale 1ns/10ps

module background_drawer (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              bg_start,
    input  logic                              buffer_select,
    output logic                              bg_en,
    output logic [render_pkg::ADDR_WIDTH-1:0] bg_addr,
    output render_pkg::color_t                bg_data,
    output logic                              bg_done
);

    localparam int AW = render_pkg::ADDR_WIDTH;
    localparam logic [AW-1:0] LAST_ADDR = AW'(render_pkg::FB_PIXELS - 1);
    localparam render_pkg::color_t BG_COLOR_0 = 12'h112;
    localparam render_pkg::color_t BG_COLOR_1 = 12'h221;

    logic active;

    assign bg_en = active;
    assign bg_done = active && (bg_addr == LAST_ADDR);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            active <= 1'b0;
            bg_addr <= '0;
        end else if (bg_start) begin
            active <= 1'b1;
            bg_addr <= '0;
        end else if (active) begin
            active <= !bg_done;
            bg_addr <= bg_addr + 1'b1;
        end
    end

    // Buffer choice is fixed for the whole clear.
    always_ff @(posedge clk) begin
        if (bg_start) begin
            bg_data <= buffer_select ? BG_COLOR_1 : BG_COLOR_0;
        end
    end

endmodule

// ==== hw/drawing_manager.sv ====
`timescale 1ns/10ps

module drawing_manager (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              draw_start,
    input  logic                              draw_ack,
    output logic                              bg_start,
    output logic                              raster_start,
    input  logic                              bg_done,
    input  logic                              raster_done,
    input  logic                              bg_en,
    input  logic [render_pkg::ADDR_WIDTH-1:0] bg_addr,
    input  render_pkg::color_t                bg_data,
    input  logic                              px_en,
    input  logic [render_pkg::ADDR_WIDTH-1:0] px_addr,
    input  render_pkg::color_t                px_data,
    output logic                              write_en,
    output logic [render_pkg::ADDR_WIDTH-1:0] write_addr,
    output render_pkg::color_t                write_data,
    output logic                              frame_done
);

    localparam int AW = render_pkg::ADDR_WIDTH;
    localparam logic [AW-1:0] MARKER_ADDR = AW'(render_pkg::FB_PIXELS - 1);
    localparam render_pkg::color_t MARKER_A = 12'hF00;
    localparam render_pkg::color_t MARKER_B = 12'h00F;

    render_pkg::draw_state_t state, next_state;
    render_pkg::color_t marker_color;

    ////////////////////////////////////////
    // Frame sequencing.
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            render_pkg::IDLE: begin
                if (draw_start) begin
                    next_state = render_pkg::BACKGROUND;
                end
            end
            render_pkg::BACKGROUND: begin
                if (bg_done) begin
                    next_state = render_pkg::GRAPHICS;
                end
            end
            render_pkg::GRAPHICS: begin
                if (raster_done) begin
                    next_state = render_pkg::MARKER;
                end
            end
            render_pkg::MARKER: next_state = render_pkg::FRAME_DONE;
            render_pkg::FRAME_DONE: begin
                if (draw_ack) begin
                    next_state = render_pkg::BACKGROUND;
                end
            end
            default: next_state = render_pkg::IDLE;
        endcase
    end

    // Steps start on the edge that enters their state.
    assign bg_start = (next_state == render_pkg::BACKGROUND) && (state != render_pkg::BACKGROUND);
    assign raster_start = (state == render_pkg::BACKGROUND) && bg_done;
    assign frame_done = (state == render_pkg::FRAME_DONE);

    ////////////////////////////////////////
    // Write port.
    ////////////////////////////////////////

    always_comb begin
        write_en = 1'b0;
        write_addr = '0;
        write_data = '0;
        case (state)
            render_pkg::BACKGROUND: begin
                write_en = bg_en;
                write_addr = bg_addr;
                write_data = bg_data;
            end
            render_pkg::GRAPHICS: begin
                write_en = px_en;
                write_addr = px_addr;
                write_data = px_data;
            end
            render_pkg::MARKER: begin
                write_en = 1'b1;
                write_addr = MARKER_ADDR;
                write_data = marker_color;
            end
            default: write_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= render_pkg::IDLE;
            marker_color <= MARKER_A;
        end else begin
            state <= next_state;
            if (state == render_pkg::MARKER) begin
                marker_color <= (marker_color == MARKER_A) ? MARKER_B : MARKER_A;
            end
        end
    end

endmodule

// ==== hw/render_top.sv ====
`timescale 1ns/10ps

module render_top #(
    parameter int LANES = 4,
    parameter int TRI_COUNT = 4
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              draw_start,
    input  logic                              draw_ack,
    input  logic                              buffer_select,
    output logic                              write_en,
    output logic [render_pkg::ADDR_WIDTH-1:0] write_addr,
    output render_pkg::color_t                write_data,
    output logic                              frame_done
);

    logic bg_start, bg_en, bg_done;
    logic [render_pkg::ADDR_WIDTH-1:0] bg_addr;
    render_pkg::color_t bg_data;

    logic raster_start, raster_done, busy;
    logic [$clog2(TRI_COUNT)-1:0] rom_addr;
    render_pkg::triangle_t rom_data, chunk_tri;
    logic chunk_valid;
    render_pkg::coord_t chunk_x, chunk_y;

    logic [LANES-1:0] lane_valid, lane_covered;
    logic [LANES-1:0][render_pkg::ADDR_WIDTH-1:0] lane_addr;
    render_pkg::color_t lane_colors [LANES];
    render_pkg::color_t lane_color;

    logic px_en;
    logic [render_pkg::ADDR_WIDTH-1:0] px_addr;
    render_pkg::color_t px_data;

    drawing_manager u_drawing_manager (
        .clk          (clk),
        .rstn         (rstn),
        .draw_start   (draw_start),
        .draw_ack     (draw_ack),
        .bg_start     (bg_start),
        .raster_start (raster_start),
        .bg_done      (bg_done),
        .raster_done  (raster_done),
        .bg_en        (bg_en),
        .bg_addr      (bg_addr),
        .bg_data      (bg_data),
        .px_en        (px_en),
        .px_addr      (px_addr),
        .px_data      (px_data),
        .write_en     (write_en),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .frame_done   (frame_done)
    );

    background_drawer u_background_drawer (
        .clk           (clk),
        .rstn          (rstn),
        .bg_start      (bg_start),
        .buffer_select (buffer_select),
        .bg_en         (bg_en),
        .bg_addr       (bg_addr),
        .bg_data       (bg_data),
        .bg_done       (bg_done)
    );

    ////////////////////////////////////////
    // Rasterizer.
    ////////////////////////////////////////

    triangle_rom #(
        .TRI_COUNT (TRI_COUNT)
    ) u_triangle_rom (
        .clk  (clk),
        .addr (rom_addr),
        .data (rom_data)
    );

    triangle_setup #(
        .LANES     (LANES),
        .TRI_COUNT (TRI_COUNT)
    ) u_triangle_setup (
        .clk          (clk),
        .rstn         (rstn),
        .raster_start (raster_start),
        .busy         (busy),
        .rom_addr     (rom_addr),
        .rom_data     (rom_data),
        .chunk_valid  (chunk_valid),
        .chunk_x      (chunk_x),
        .chunk_y      (chunk_y),
        .chunk_tri    (chunk_tri),
        .raster_done  (raster_done)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        edge_tester #(
            .LANE (i)
        ) u_edge_tester (
            .clk          (clk),
            .rstn         (rstn),
            .chunk_valid  (chunk_valid),
            .chunk_x      (chunk_x),
            .chunk_y      (chunk_y),
            .chunk_tri    (chunk_tri),
            .lane_valid   (lane_valid[i]),
            .lane_covered (lane_covered[i]),
            .lane_addr    (lane_addr[i]),
            .lane_color   (lane_colors[i])
        );
    end

    // Every lane carries the same triangle color.
    assign lane_color = lane_colors[0];

    pixel_collector #(
        .LANES (LANES)
    ) u_pixel_collector (
        .clk          (clk),
        .rstn         (rstn),
        .lane_valid   (lane_valid),
        .lane_covered (lane_covered),
        .lane_addr    (lane_addr),
        .lane_color   (lane_color),
        .busy         (busy),
        .px_en        (px_en),
        .px_addr      (px_addr),
        .px_data      (px_data)
    );

endmodule

// ==== test/render_assertions.sv ====
`timescale 1ns/10ps

module render_assertions (
    input logic                              clk,
    input logic                              rstn,
    input logic                              draw_ack,
    input logic                              write_en,
    input logic [render_pkg::ADDR_WIDTH-1:0] write_addr,
    input logic                              frame_done
);

    localparam int AW = render_pkg::ADDR_WIDTH;
    localparam logic [AW-1:0] PIXELS = AW'(render_pkg::FB_PIXELS);

    // A finished frame keeps the write port quiet.
    no_write_in_done: assert property (@(posedge clk) disable iff (!rstn)
        frame_done |-> !write_en)
        else $error("write_en high while frame_done is high");

    addr_in_range: assert property (@(posedge clk) disable iff (!rstn)
        write_en |-> (write_addr < PIXELS))
        else $error("write_addr outside the frame buffer");

    // Only draw_ack releases frame_done.
    done_until_ack: assert property (@(posedge clk) disable iff (!rstn)
        (frame_done && !draw_ack) |=> frame_done)
        else $error("frame_done dropped without draw_ack");

    quiet_in_reset: assert property (@(posedge clk)
        !rstn |-> (!write_en && !frame_done))
        else $error("write_en or frame_done high during reset");

endmodule

bind render_top render_assertions u_render_assertions (
    .clk        (clk),
    .rstn       (rstn),
    .draw_ack   (draw_ack),
    .write_en   (write_en),
    .write_addr (write_addr),
    .frame_done (frame_done)
);

// ==== test/render_tb.sv ====
`timescale 1ns/10ps

module render_tb;

    localparam int LANES = 4;
    localparam int TRI_COUNT = 4;
    localparam int NUM_ROWS = 4;
    localparam int RESET_CYCLES = 16;
    localparam int PIXELS = render_pkg::FB_PIXELS;
    localparam int FRAME_BUDGET = PIXELS + TRI_COUNT * PIXELS * 2 + 8 + 20;
    localparam int CYCLE_LIMIT = NUM_ROWS * FRAME_BUDGET + RESET_CYCLES;

    logic clk;
    logic rstn;
    logic draw_start;
    logic draw_ack;
    logic buffer_select;
    logic write_en;
    logic [render_pkg::ADDR_WIDTH-1:0] write_addr;
    render_pkg::color_t write_data;
    logic frame_done;

    // A delay of 0 draws the ack delay from the LCG.
    string row_name [NUM_ROWS] = '{"frame_buf0_a", "frame_buf1_a", "frame_buf0_b", "frame_buf1_b"};
    logic row_buffer [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1};
    int row_ack_delay [NUM_ROWS] = '{3, 0, 5, 0};
    render_pkg::color_t row_marker [NUM_ROWS] = '{12'hF00, 12'h00F, 12'hF00, 12'h00F};

    logic [$bits(render_pkg::triangle_t)-1:0] tri_words [TRI_COUNT];
    render_pkg::color_t ref_img [PIXELS];
    render_pkg::color_t shadow [PIXELS];
    logic [31:0] lcg_state;
    int checks = 0;
    int errors = 0;
    int cycles = 0;

    render_top #(
        .LANES     (LANES),
        .TRI_COUNT (TRI_COUNT)
    ) u_render_top (
        .clk           (clk),
        .rstn          (rstn),
        .draw_start    (draw_start),
        .draw_ack      (draw_ack),
        .buffer_select (buffer_select),
        .write_en      (write_en),
        .write_addr    (write_addr),
        .write_data    (write_data),
        .frame_done    (frame_done)
    );

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // Checks and reference model.
    ////////////////////////////////////////

    task automatic check_color(input string name, input render_pkg::color_t expected,
                               input render_pkg::color_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic render_pkg::color_t bg_color(input logic buffer);
        return buffer ? 12'h221 : 12'h112;
    endfunction

    function automatic int edge_value(input int xa, input int ya, input int xb, input int yb,
                                      input int x, input int y);
        return (x - xa) * (yb - ya) - (y - ya) * (xb - xa);
    endfunction

    // Inside when all three edges agree in sign and zero agrees with both.
    function automatic bit inside_triangle(input render_pkg::triangle_t t, input int x,
                                           input int y);
        int e0;
        int e1;
        int e2;
        e0 = edge_value(t.x0, t.y0, t.x1, t.y1, x, y);
        e1 = edge_value(t.x1, t.y1, t.x2, t.y2, x, y);
        e2 = edge_value(t.x2, t.y2, t.x0, t.y0, x, y);
        return (e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0);
    endfunction

    task automatic build_reference(input logic buffer, input render_pkg::color_t marker);
        render_pkg::triangle_t t;
        for (int a = 0; a < PIXELS; a++) begin
            ref_img[a] = bg_color(buffer);
        end
        // Later triangles land on top.
        for (int i = 0; i < TRI_COUNT; i++) begin
            t = tri_words[i];
            for (int y = 0; y < render_pkg::FB_HEIGHT; y++) begin
                for (int x = 0; x < render_pkg::FB_WIDTH; x++) begin
                    if (inside_triangle(t, x, y)) begin
                        ref_img[x + y * render_pkg::FB_WIDTH] = t.color;
                    end
                end
            end
        end
        ref_img[PIXELS - 1] = marker;
    endtask

    task automatic compare_frame(input int r);
        for (int a = 0; a < PIXELS; a++) begin
            check_color($sformatf("%s pixel %0d", row_name[r], a), ref_img[a], shadow[a]);
        end
        check_color($sformatf("%s background", row_name[r]), bg_color(row_buffer[r]), shadow[0]);
        check_color($sformatf("%s marker", row_name[r]), row_marker[r], shadow[PIXELS - 1]);
    endtask

    task automatic clear_shadow();
        for (int a = 0; a < PIXELS; a++) begin
            shadow[a] = 'x;
        end
    endtask

    task automatic wait_frame_done();
        while (frame_done !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    ////////////////////////////////////////
    // Monitors.
    ////////////////////////////////////////

    // Shadow frame from the observed write port.
    always @(negedge clk) begin
        if (rstn && write_en) begin
            shadow[write_addr] = write_data;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            errors++;
            $display("timeout: frame_done never came within %0d cycles", CYCLE_LIMIT);
            end_run();
        end
    end

    ////////////////////////////////////////
    // Stimulus.
    ////////////////////////////////////////

    initial begin
        int delay;
        rstn = 1'b0;
        draw_start = 1'b0;
        draw_ack = 1'b0;
        buffer_select = 1'b0;
        lcg_state = 32'hf68f0e28;
        $readmemh("triangles.hex", tri_words);
        clear_shadow();

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_flag("reset write_en", 1'b0, write_en);
            check_flag("reset frame_done", 1'b0, frame_done);
        end
        rstn = 1'b1;

        // Port stays quiet until the first start.
        repeat (4) begin
            @(negedge clk);
            check_flag("idle write_en", 1'b0, write_en);
            check_flag("idle frame_done", 1'b0, frame_done);
        end

        buffer_select = row_buffer[0];
        draw_start = 1'b1;
        @(negedge clk);
        draw_start = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            wait_frame_done();
            build_reference(row_buffer[r], row_marker[r]);
            compare_frame(r);

            if (row_ack_delay[r] != 0) begin
                delay = row_ack_delay[r];
            end else begin
                delay = int'((next_random() >> 16) % 32'd8);
            end
            repeat (delay) begin
                @(negedge clk);
                check_flag($sformatf("%s frame_done held", row_name[r]), 1'b1, frame_done);
                check_flag($sformatf("%s no write in done", row_name[r]), 1'b0, write_en);
            end

            @(negedge clk);
            clear_shadow();
            if (r + 1 < NUM_ROWS) begin
                buffer_select = row_buffer[r + 1];
            end
            draw_ack = 1'b1;
            @(negedge clk);
            draw_ack = 1'b0;
            // Next clear starts right after the ack.
            check_flag($sformatf("%s done after ack", row_name[r]), 1'b0, frame_done);
            check_flag($sformatf("%s restart write", row_name[r]), 1'b1, write_en);
        end

        end_run();
    end

endmodule

// ==== triangles.hex ====
// x0 y0 x1 y1 x2 y2 then color (r g b), one hex digit per field.
// One triangle per line, drawn in line order.
11A2398A4
60F59B4C8
0B74DBC4C
C1E1D3FF0

// ==== vlog.f ====
hw/render_pkg.sv
hw/triangle_rom.sv
hw/triangle_setup.sv
hw/edge_tester.sv
hw/pixel_collector.sv
hw/background_drawer.sv
hw/drawing_manager.sv
hw/render_top.sv
test/render_assertions.sv
test/render_tb.sv

// ==== Makefile ====
TOP = render_tb

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f vlog.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/10ps \
		-f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
